/* all.f */
+incdir+include
design/setup_pkg.sv
design/mem_pkg.sv
design/setup_sequencer.sv
design/read_request_gen.sv
design/response_tracker.sv
design/cu_setup_top.sv
sim/tb_cu_setup.sv

/* run.sh */
#!/bin/sh
# Build and run the CU setup testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f all.f --top-module tb_cu_setup

./obj_dir/Vtb_cu_setup > sim.log
cat sim.log

if grep -qxF '** PASS **' sim.log; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi

/* sim/tb_cu_setup.sv */
// CU setup stage testbench
`timescale 1ns/100ps
`include "cu_setup_config.svh"

module tb_cu_setup;

    localparam int DRIVE_DELAY     = 1;
    localparam int TEST_SIZE_SUM   = 12 + 40 + 12 + 8 + 0;
    localparam int WATCHDOG_CYCLES = TEST_SIZE_SUM * 40 + 2000;

    logic               ap_clk;
    logic               areset_cu_setup;
    logic               descriptor_valid;
    logic [`DESC_W-1:0] descriptor;
    logic               cu_flush;
    logic               response_valid;
    logic               request_ready;
    logic               request_valid;
    mem_pkg::mem_cmd_e  request_cmd;
    logic [`ADDR_W-1:0] request_addr;
    logic               done_out;

    // Observed requests and response bookkeeping
    logic [`ADDR_W-1:0] seen_addr [$];
    logic [1:0]         seen_cmd [$];
    int                 resp_count = 0;
    logic               hold_responses = 1'b0;
    integer             seed = 32'h5189_ba96;

    int error_count  = 0;
    int test_count   = 0;
    int failed_tests = 0;

    cu_setup_top u_dut (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_valid (descriptor_valid),
        .descriptor       (descriptor),
        .cu_flush         (cu_flush),
        .response_valid   (response_valid),
        .request_ready    (request_ready),
        .request_valid    (request_valid),
        .request_cmd      (request_cmd),
        .request_addr     (request_addr),
        .done_out         (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    // ----------------------------------------------------------------------
    // Request monitor and memory responder
    // ----------------------------------------------------------------------
    initial begin
        forever begin
            @(negedge ap_clk);
            if (!areset_cu_setup && request_valid === 1'b1) begin
                seen_addr.push_back(request_addr);
                seen_cmd.push_back(request_cmd);
            end
        end
    end

    // One pulse per observed request with a random gap of 0 to 3 cycles
    initial begin : responder
        int wait_cycles;
        wait_cycles = 0;
        response_valid = 1'b0;
        forever begin
            @(posedge ap_clk);
            #DRIVE_DELAY;
            response_valid = 1'b0;
            if (wait_cycles > 0) begin
                wait_cycles = wait_cycles - 1;
            end else if (seen_addr.size() > resp_count && !hold_responses) begin
                response_valid = 1'b1;
                resp_count = resp_count + 1;
                wait_cycles = $unsigned($random(seed)) % 4;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic step(input int cycles);
        repeat (cycles) @(posedge ap_clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error in %s: expected %0h, actual %0h", name, expected, actual);
            error_count = error_count + 1;
        end
    endtask

    function automatic logic [`DESC_W-1:0] make_descriptor(input logic flush_en,
                                                           input int prog_size,
                                                           input int flush_size);
        logic [`DESC_W-1:0] desc;
        desc = '0;
        desc[`FLUSH_EN_BIT] = flush_en;
        desc[`PROG_MSB:`PROG_LSB] = prog_size[`PROG_MSB-`PROG_LSB:0];
        desc[`FLUSH_MSB:`FLUSH_LSB] = flush_size[`FLUSH_MSB-`FLUSH_LSB:0];
        return desc;
    endfunction

    task automatic apply_reset();
        areset_cu_setup = 1'b1;
        descriptor_valid = 1'b0;
        cu_flush = 1'b0;
        request_ready = 1'b1;
        hold_responses = 1'b0;
        step(16);
        areset_cu_setup = 1'b0;
        step(3);
    endtask

    task automatic present_descriptor(input logic [`DESC_W-1:0] desc);
        descriptor = desc;
        descriptor_valid = 1'b1;
        step(1);
        descriptor_valid = 1'b0;
    endtask

    task automatic wait_for_done(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (done_out !== 1'b1 && cycles < limit) begin
            step(1);
            cycles = cycles + 1;
        end
        if (done_out !== 1'b1) begin
            $display("Test %s: done_out never rose within %0d cycles", name, limit);
            error_count = error_count + 1;
        end
    endtask

    task automatic wait_for_requests(input string name, input int total, input int limit);
        int cycles;
        cycles = 0;
        while (seen_addr.size() < total && cycles < limit) begin
            step(1);
            cycles = cycles + 1;
        end
        if (seen_addr.size() < total) begin
            $display("Test %s: only %0d requests seen, waited for %0d", name,
                     seen_addr.size(), total);
            error_count = error_count + 1;
        end
    endtask

    task automatic wait_for_responses(input string name, input int total, input int limit);
        int cycles;
        cycles = 0;
        while (resp_count < total && cycles < limit) begin
            step(1);
            cycles = cycles + 1;
        end
        if (resp_count < total) begin
            $display("Test %s: responses stalled at %0d of %0d", name, resp_count, total);
            error_count = error_count + 1;
        end
    endtask

    // Indices 0 to count-1 in order with one command for the whole run
    task automatic check_sequence(input string name, input int first, input int count,
                                  input logic [1:0] cmd);
        for (int i = 0; i < count; i++) begin
            check_value({name, " addr"}, 32'(i) << `WORD_SHIFT, seen_addr[first + i]);
            check_value({name, " cmd"}, 32'(cmd), 32'(seen_cmd[first + i]));
        end
    endtask

    task automatic check_done_held(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            step(1);
            check_value({name, " done held"}, 32'd1, 32'(done_out));
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count = test_count + 1;
        if (error_count == errors_before) begin
            $display("Test %s passed", name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("Test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic idle_after_reset();
        int errors_before;
        errors_before = error_count;
        apply_reset();
        for (int i = 0; i < 40; i++) begin
            step(1);
            check_value("reset request_valid", 32'd0, 32'(request_valid));
            check_value("reset done_out", 32'd0, 32'(done_out));
        end
        report_test("reset_state", errors_before);
    endtask

    task automatic program_only_run();
        int errors_before;
        int base;
        errors_before = error_count;
        apply_reset();
        base = seen_addr.size();
        present_descriptor(make_descriptor(1'b0, 12, 0));
        wait_for_done("program_only", 12 * 40 + 200);
        check_value("program_only count", 32'd12, 32'(seen_addr.size() - base));
        check_value("program_only responses", 32'(seen_addr.size()), 32'(resp_count));
        check_sequence("program_only", base, 12, mem_pkg::mem_read);
        check_done_held("program_only", 10);
        report_test("program_only", errors_before);
    endtask

    task automatic back_pressure_run();
        int errors_before;
        int base;
        errors_before = error_count;
        apply_reset();
        request_ready = 1'b0;
        base = seen_addr.size();
        present_descriptor(make_descriptor(1'b0, 40, 0));
        step(60);
        check_value("back_pressure stalled count", 32'd0, 32'(seen_addr.size() - base));
        request_ready = 1'b1;
        wait_for_done("back_pressure", 40 * 40 + 200);
        check_value("back_pressure count", 32'd40, 32'(seen_addr.size() - base));
        check_value("back_pressure responses", 32'(seen_addr.size()), 32'(resp_count));
        check_sequence("back_pressure", base, 40, mem_pkg::mem_read);
        report_test("back_pressure", errors_before);
    endtask

    task automatic flush_phase_run();
        int errors_before;
        int base;
        errors_before = error_count;
        apply_reset();
        base = seen_addr.size();
        present_descriptor(make_descriptor(1'b1, 5, 7));
        wait_for_requests("flush_phase", base + 5, 5 * 40 + 200);
        wait_for_responses("flush_phase", base + 5, 5 * 40 + 200);
        // Nothing may move until cu_flush once the program phase is over
        step(30);
        check_value("flush_phase before flush count", 32'd5, 32'(seen_addr.size() - base));
        check_value("flush_phase before flush done", 32'd0, 32'(done_out));
        cu_flush = 1'b1;
        wait_for_done("flush_phase", 7 * 40 + 200);
        check_value("flush_phase count", 32'd12, 32'(seen_addr.size() - base));
        check_value("flush_phase responses", 32'(seen_addr.size()), 32'(resp_count));
        check_sequence("flush_phase program", base, 5, mem_pkg::mem_read);
        check_sequence("flush_phase flush", base + 5, 7, mem_pkg::mem_flush_read);
        report_test("flush_phase", errors_before);
    endtask

    task automatic response_gating_run();
        int errors_before;
        int base;
        errors_before = error_count;
        apply_reset();
        hold_responses = 1'b1;
        base = seen_addr.size();
        present_descriptor(make_descriptor(1'b0, 8, 0));
        wait_for_requests("response_gating", base + 8, 8 * 40 + 200);
        for (int i = 0; i < 40; i++) begin
            step(1);
            check_value("response_gating withheld done", 32'd0, 32'(done_out));
        end
        hold_responses = 1'b0;
        wait_for_done("response_gating", 8 * 40 + 200);
        check_value("response_gating responses", 32'(seen_addr.size()), 32'(resp_count));
        check_sequence("response_gating", base, 8, mem_pkg::mem_read);
        report_test("response_gating", errors_before);
    endtask

    task automatic zero_size_run();
        int errors_before;
        int base;
        errors_before = error_count;
        apply_reset();
        base = seen_addr.size();
        present_descriptor(make_descriptor(1'b0, 0, 0));
        wait_for_done("zero_size", 200);
        check_value("zero_size count", 32'd0, 32'(seen_addr.size() - base));
        check_done_held("zero_size", 10);
        report_test("zero_size", errors_before);
    endtask

    initial begin
        areset_cu_setup = 1'b1;
        descriptor_valid = 1'b0;
        descriptor = '0;
        cu_flush = 1'b0;
        request_ready = 1'b1;
        idle_after_reset();
        program_only_run();
        back_pressure_run();
        flush_phase_run();
        response_gating_run();
        zero_size_run();
        $display("Tests run %0d, tests failed %0d, errors %0d", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_cu_setup

/* design/cu_setup_top.sv */
// Compute unit setup stage
`timescale 1ns/100ps
`include "cu_setup_config.svh"

module cu_setup_top (
    input  logic               ap_clk,
    input  logic               areset_cu_setup,
    input  logic               descriptor_valid,
    input  logic [`DESC_W-1:0] descriptor,
    input  logic               cu_flush,
    input  logic               response_valid,
    input  logic               request_ready,
    output logic               request_valid,
    output mem_pkg::mem_cmd_e  request_cmd,
    output logic [`ADDR_W-1:0] request_addr,
    output logic               done_out
);

    logic               descriptor_valid_q;
    logic [`DESC_W-1:0] descriptor_q;
    logic               cu_flush_q;
    logic               response_valid_q;
    logic               request_ready_q;

    logic               gen_start;
    logic [`SIZE_W-1:0] gen_count;
    setup_pkg::phase_e  gen_phase;
    logic               gen_idle;
    logic               gen_paused;
    logic               track_load;
    logic [`SIZE_W-1:0] track_value;
    logic               track_zero;
    logic               seq_done;
    logic               gen_req_valid;
    mem_pkg::mem_cmd_e  gen_req_cmd;
    logic [`ADDR_W-1:0] gen_req_addr;

    // ----------------------------------------------------------------------
    // Input registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            descriptor_valid_q <= 1'b0;
            cu_flush_q         <= 1'b0;
            response_valid_q   <= 1'b0;
            request_ready_q    <= 1'b0;
        end else begin
            descriptor_valid_q <= descriptor_valid;
            cu_flush_q         <= cu_flush;
            response_valid_q   <= response_valid;
            request_ready_q    <= request_ready;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_q <= descriptor;
    end

    // ----------------------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            request_valid <= 1'b0;
            done_out      <= 1'b0;
        end else begin
            request_valid <= gen_req_valid;
            done_out      <= seq_done;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_cmd  <= gen_req_cmd;
        request_addr <= gen_req_addr;
    end

    // Sequencer joins the generator and tracker status
    setup_sequencer u_sequencer (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_valid (descriptor_valid_q),
        .descriptor       (descriptor_q),
        .cu_flush         (cu_flush_q),
        .gen_idle         (gen_idle),
        .gen_paused       (gen_paused),
        .track_zero       (track_zero),
        .gen_start        (gen_start),
        .gen_count        (gen_count),
        .gen_phase        (gen_phase),
        .track_load       (track_load),
        .track_value      (track_value),
        .done_out         (seq_done)
    );

    read_request_gen u_request_gen (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .gen_start       (gen_start),
        .gen_count       (gen_count),
        .gen_phase       (gen_phase),
        .request_ready   (request_ready_q),
        .gen_idle        (gen_idle),
        .gen_paused      (gen_paused),
        .request_valid   (gen_req_valid),
        .request_cmd     (gen_req_cmd),
        .request_addr    (gen_req_addr)
    );

    response_tracker u_response_tracker (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .track_load      (track_load),
        .track_value     (track_value),
        .response_valid  (response_valid_q),
        .track_zero      (track_zero)
    );

endmodule : cu_setup_top

/* design/response_tracker.sv */
// Outstanding response counter
`timescale 1ns/100ps
`include "cu_setup_config.svh"

module response_tracker (
    input  logic               ap_clk,
    input  logic               areset_cu_setup,
    input  logic               track_load,
    input  logic [`SIZE_W-1:0] track_value,
    input  logic               response_valid,
    output logic               track_zero
);

    localparam int SIZE_W = `SIZE_W;

    logic [SIZE_W-1:0] outstanding;

    // ----------------------------------------------------------------------
    // Down counter
    // ----------------------------------------------------------------------

    // Load wins over a response in the same cycle
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            outstanding <= '0;
        end else if (track_load) begin
            outstanding <= track_value;
        end else if (response_valid && outstanding != '0) begin
            // Stray responses at zero are ignored
            outstanding <= outstanding - SIZE_W'(1);
        end
    end

    assign track_zero = (outstanding == '0);

endmodule : response_tracker

/* design/read_request_gen.sv */
// Serial read request generator
`timescale 1ns/100ps
`include "cu_setup_config.svh"

module read_request_gen (
    input  logic                ap_clk,
    input  logic                areset_cu_setup,
    input  logic                gen_start,
    input  logic [`SIZE_W-1:0]  gen_count,
    input  setup_pkg::phase_e   gen_phase,
    input  logic                request_ready,
    output logic                gen_idle,
    output logic                gen_paused,
    output logic                request_valid,
    output mem_pkg::mem_cmd_e   request_cmd,
    output logic [`ADDR_W-1:0]  request_addr
);

    localparam int SIZE_W = `SIZE_W;
    localparam int ADDR_W = `ADDR_W;
    localparam int DEPTH  = `REQ_FIFO_DEPTH;
    localparam int THRESH = `REQ_PROG_THRESH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int FILL_W = $clog2(DEPTH + 1);

    logic              active;
    logic [SIZE_W-1:0] index;
    logic [SIZE_W-1:0] count_q;
    mem_pkg::mem_cmd_e cmd_q;
    logic              last_index;

    logic [ADDR_W-1:0] addr_mem [DEPTH];
    mem_pkg::mem_cmd_e cmd_mem  [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [FILL_W-1:0] fill;
    logic              fifo_empty;
    logic              wr_en;
    logic              rd_en;

    // ----------------------------------------------------------------------
    // Index counter
    // ----------------------------------------------------------------------
    assign last_index = (index == count_q - SIZE_W'(1));
    assign wr_en      = active & ~gen_paused;

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            active <= 1'b0;
            index  <= '0;
        end else if (gen_start) begin
            // Empty array leaves the generator idle
            active <= (gen_count != '0);
            index  <= '0;
        end else if (wr_en) begin
            if (last_index) begin
                active <= 1'b0;
            end
            index <= index + SIZE_W'(1);
        end
    end

    // Count and command held for the phase
    always_ff @(posedge ap_clk) begin
        if (gen_start) begin
            count_q <= gen_count;
            if (gen_phase == setup_pkg::phase_flush) begin
                cmd_q <= mem_pkg::mem_flush_read;
            end else begin
                cmd_q <= mem_pkg::mem_read;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Request FIFO
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            addr_mem[wr_ptr] <= ADDR_W'(index) << `WORD_SHIFT;
            cmd_mem[wr_ptr]  <= cmd_q;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   fill <= fill + FILL_W'(1);
                2'b01:   fill <= fill - FILL_W'(1);
                default: fill <= fill;
            endcase
        end
    end

    assign fifo_empty = (fill == '0);

    // Writes stop at the threshold, so the FIFO never fills
    assign gen_paused = (fill >= FILL_W'(THRESH));

    // Pop the head whenever downstream can take it
    assign rd_en         = request_ready & ~fifo_empty;
    assign request_valid = rd_en;
    assign request_addr  = addr_mem[rd_ptr];
    assign request_cmd   = cmd_mem[rd_ptr];

    assign gen_idle = ~active & fifo_empty;

endmodule : read_request_gen

/* design/setup_sequencer.sv */
// Setup phase sequencer
`timescale 1ns/100ps
`include "cu_setup_config.svh"

module setup_sequencer (
    input  logic                      ap_clk,
    input  logic                      areset_cu_setup,
    input  logic                      descriptor_valid,
    input  logic [`DESC_W-1:0]        descriptor,
    input  logic                      cu_flush,
    input  logic                      gen_idle,
    input  logic                      gen_paused,
    input  logic                      track_zero,
    output logic                      gen_start,
    output logic [`SIZE_W-1:0]        gen_count,
    output setup_pkg::phase_e         gen_phase,
    output logic                      track_load,
    output logic [`SIZE_W-1:0]        track_value,
    output logic                      done_out
);

    localparam int SIZE_W = `SIZE_W;

    logic [`DESC_W-1:0]      desc_q;
    logic                    flush_q;
    logic                    flush_en;
    logic [SIZE_W-1:0]       prog_size;
    logic [SIZE_W-1:0]       flush_size;
    logic                    phase_end;
    setup_pkg::phase_e       phase_q;
    setup_pkg::setup_state_e state;
    setup_pkg::setup_state_e next_state;

    // ----------------------------------------------------------------------
    // Descriptor and flush input registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == setup_pkg::setup_idle && descriptor_valid) begin
            desc_q <= descriptor;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= cu_flush;
        end
    end

    // Field decode
    assign flush_en   = desc_q[`FLUSH_EN_BIT];
    assign prog_size  = SIZE_W'(desc_q[`PROG_MSB:`PROG_LSB]);
    assign flush_size = SIZE_W'(desc_q[`FLUSH_MSB:`FLUSH_LSB]);

    // All requests gone and all responses back
    assign phase_end = gen_idle & track_zero;

    // ----------------------------------------------------------------------
    // Phase state machine
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state <= setup_pkg::setup_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            setup_pkg::setup_reset: begin
                next_state = setup_pkg::setup_idle;
            end
            setup_pkg::setup_idle: begin
                if (descriptor_valid) begin
                    next_state = setup_pkg::setup_prog_start;
                end
            end
            setup_pkg::setup_prog_start: begin
                next_state = setup_pkg::setup_prog_busy;
            end
            setup_pkg::setup_prog_busy: begin
                if (phase_end) begin
                    next_state = setup_pkg::setup_prog_done;
                end else if (gen_paused) begin
                    next_state = setup_pkg::setup_prog_pause;
                end
            end
            setup_pkg::setup_prog_pause: begin
                if (phase_end) begin
                    next_state = setup_pkg::setup_prog_done;
                end else if (!gen_paused) begin
                    next_state = setup_pkg::setup_prog_busy;
                end
            end
            setup_pkg::setup_prog_done: begin
                // Skip the flush phase entirely when it is not enabled
                if (!flush_en) begin
                    next_state = setup_pkg::setup_flush_done;
                end else if (flush_q) begin
                    next_state = setup_pkg::setup_flush_start;
                end
            end
            setup_pkg::setup_flush_start: begin
                next_state = setup_pkg::setup_flush_busy;
            end
            setup_pkg::setup_flush_busy: begin
                if (phase_end) begin
                    next_state = setup_pkg::setup_flush_done;
                end else if (gen_paused) begin
                    next_state = setup_pkg::setup_flush_pause;
                end
            end
            setup_pkg::setup_flush_pause: begin
                if (phase_end) begin
                    next_state = setup_pkg::setup_flush_done;
                end else if (!gen_paused) begin
                    next_state = setup_pkg::setup_flush_busy;
                end
            end
            setup_pkg::setup_flush_done: begin
                next_state = setup_pkg::setup_flush_done;
            end
            default: begin
                next_state = setup_pkg::setup_reset;
            end
        endcase
    end

    // Phase flag held for the whole phase
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            phase_q <= setup_pkg::phase_program;
        end else if (next_state == setup_pkg::setup_flush_start) begin
            phase_q <= setup_pkg::phase_flush;
        end else if (next_state == setup_pkg::setup_prog_start) begin
            phase_q <= setup_pkg::phase_program;
        end
    end

    // ----------------------------------------------------------------------
    // Worker controls
    // ----------------------------------------------------------------------
    assign gen_start = (state == setup_pkg::setup_prog_start) ||
                       (state == setup_pkg::setup_flush_start);
    assign track_load = gen_start;

    assign gen_phase   = phase_q;
    assign gen_count   = (phase_q == setup_pkg::phase_flush) ? flush_size : prog_size;
    assign track_value = gen_count;

    assign done_out = (state == setup_pkg::setup_flush_done);

endmodule : setup_sequencer

/* design/mem_pkg.sv */
// Memory request types
package mem_pkg;

    // Command carried with every request
    //   mem_read       array read in the program phase
    //   mem_flush_read read issued while flushing
    typedef enum logic [1:0] {
        mem_read       = 2'd1,
        mem_flush_read = 2'd2
    } mem_cmd_e;

endpackage : mem_pkg

/* design/setup_pkg.sv */
// Setup sequencer types
package setup_pkg;

    // Sequencer states for the program phase then the flush phase
    typedef enum logic [3:0] {
        setup_reset       = 4'd0,
        setup_idle        = 4'd1,
        setup_prog_start  = 4'd2,
        setup_prog_busy   = 4'd3,
        setup_prog_pause  = 4'd4,
        setup_prog_done   = 4'd5,
        setup_flush_start = 4'd6,
        setup_flush_busy  = 4'd7,
        setup_flush_pause = 4'd8,
        setup_flush_done  = 4'd9
    } setup_state_e;

    // Which read phase is running
    typedef enum logic {
        phase_program = 1'b0,
        phase_flush   = 1'b1
    } phase_e;

endpackage : setup_pkg

/* include/cu_setup_config.svh */
// CU setup configuration
`ifndef CU_SETUP_CONFIG_SVH
`define CU_SETUP_CONFIG_SVH

// ----------------------------------------------------------------------
// Widths
// ----------------------------------------------------------------------
`define DESC_W 32
`define SIZE_W 16
`define ADDR_W 32

// Eight bytes per memory word
`define WORD_SHIFT 3

// ----------------------------------------------------------------------
// Descriptor fields
// ----------------------------------------------------------------------
`define FLUSH_EN_BIT 2
`define PROG_LSB 3
`define PROG_MSB 15
`define FLUSH_LSB 16
`define FLUSH_MSB 31

// Request FIFO sizing
`define REQ_FIFO_DEPTH 32
`define REQ_PROG_THRESH 16

`endif
